// File: common/trellisPkg.sv
/*
 * Trellis shell types
 * vector typedefs shared by the shell RTL and its testbench
 */
package trellisPkg;

`include "trellis_macros.svh"

   // -------------------- sample path
   // signed I/Q sample, 2x symbol rate
   typedef logic signed [`SAMPLE_BITS-1:0] sample_t;

   // phase error from the trellis decoder
   typedef logic signed [`PHERR_BITS-1:0] phaseErr_t;

   // clamped loop-filter word
   typedef logic [`PHSHFT_BITS-1:0] phErrShft_t;

   // winning trellis state index
   typedef logic [`INDEX_BITS-1:0] trellisIndex_t;

   // -------------------- monitor outputs
   // offset-free DAC word, same width as a sample
   typedef logic [`SAMPLE_BITS-1:0] dacWord_t;

   // per-channel source select
   typedef logic [`DAC_SEL_BITS-1:0] dacSel_t;

   // -------------------- register bus
   typedef logic [`REG_ADDR_BITS-1:0] regAddr_t;
   typedef logic [`REG_DATA_BITS-1:0] regData_t;

   // path-metric decay factor fed to the Viterbi core
   typedef logic [`DECAY_BITS-1:0] decay_t;

endpackage

// File: common/trellis_macros.svh
/*
 * Trellis demodulator shell constants
 * widths, register map, DAC monitor select codes and the
 * clamp words of the phase-error saturator
 */
`ifndef TRELLIS_MACROS_SVH
`define TRELLIS_MACROS_SVH

// -------------------- datapath widths
`define SAMPLE_BITS 18
`define PHERR_BITS 10
// loop-filter word after clamping
`define PHSHFT_BITS 8
`define INDEX_BITS 6
`define DAC_SEL_BITS 4

// -------------------- register bus
`define REG_ADDR_BITS 12
`define REG_DATA_BITS 32
`define DECAY_BITS 8

// upper address byte that selects the trellis space
`define TRELLIS_SPACE_TAG 8'h5a
// decay register, first word of the trellis space
`define TRELLIS_DECAY 12'h5a0
`define DECAY_RESET 8'hff

// -------------------- DAC monitor sources
`define DAC_TRELLIS_I 4'h0
`define DAC_TRELLIS_Q 4'h1
`define DAC_TRELLIS_PHERR 4'h2
`define DAC_TRELLIS_INDEX 4'h3

// clamp words, +/- full scale of the 8-bit loop-filter input
`define PHSHFT_POS_SAT 8'h7f
`define PHSHFT_NEG_SAT 8'h81

`endif

// File: dacMux/dacMux.sv
/*
 * DAC monitor mux
 * latches I/Q on the 2x symbol enable and drives three registered
 * monitor channels, each with its own source select
 */
`timescale 1ns/1ps
`include "trellis_macros.svh"

module dacMux (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      sym2xEn,
   input  logic                      quadSymEn,
   input  trellisPkg::sample_t       iIn,
   input  trellisPkg::sample_t       qIn,
   input  trellisPkg::phaseErr_t     phaseError,
   input  trellisPkg::trellisIndex_t index,
   input  trellisPkg::dacSel_t       dac0Select,
   input  trellisPkg::dacSel_t       dac1Select,
   input  trellisPkg::dacSel_t       dac2Select,
   output logic                      dac0Sync,
   output logic                      dac1Sync,
   output logic                      dac2Sync,
   output trellisPkg::dacWord_t      dac0Data,
   output trellisPkg::dacWord_t      dac1Data,
   output trellisPkg::dacWord_t      dac2Data
);

   import trellisPkg::*;

   // --------------------
   // I/Q sample latch
   sample_t iInLatch;
   sample_t qInLatch;

   always_ff @(posedge clk) begin
      if (sym2xEn) begin
         iInLatch <= iIn;
         qInLatch <= qIn;
      end
   end

   // --------------------
   // source words

   // phase error, left justified
   dacWord_t pherrWord;
   // index in the top six bits
   dacWord_t indexWord;

   assign pherrWord = {phaseError, {(`SAMPLE_BITS-`PHERR_BITS){1'b0}}};
   assign indexWord = {index, {(`SAMPLE_BITS-`INDEX_BITS){1'b0}}};

   // unknown codes fall back to the phase error
   function automatic dacWord_t dacSource(input dacSel_t sel);
      case (sel)
         `DAC_TRELLIS_I: dacSource = iInLatch;
         `DAC_TRELLIS_Q: dacSource = qInLatch;
         `DAC_TRELLIS_PHERR: dacSource = pherrWord;
         `DAC_TRELLIS_INDEX: dacSource = indexWord;
         default: dacSource = pherrWord;
      endcase
   endfunction

   // --------------------
   // output registers, data every clock
   // syncs mark the quadrary enable one clock late
   always_ff @(posedge clk) begin
      if (reset) begin
         dac0Sync <= 1'b0;
         dac1Sync <= 1'b0;
         dac2Sync <= 1'b0;
         dac0Data <= '0;
         dac1Data <= '0;
         dac2Data <= '0;
      end
      else begin
         dac0Sync <= quadSymEn;
         dac1Sync <= quadSymEn;
         dac2Sync <= quadSymEn;
         dac0Data <= dacSource(dac0Select);
         dac1Data <= dacSource(dac1Select);
         dac2Data <= dacSource(dac2Select);
      end
   end

endmodule

// File: project.f
+incdir+common
common/trellisPkg.sv
verilog/trellisCtrl.sv
verilog/phaseErrSat.sv
dacMux/dacMux.sv
verilog/trellisShell.sv
tb/trellisShell_sva.sv
tb/trellisShell_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the trellis shell testbench

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f project.f --top-module trellisShell_tb \
   --Mdir "$BUILD_DIR" -o trellisShell_sim
if [ $? -ne 0 ]; then
   echo "run.sh: verilator compile failed"
   exit 1
fi

"./$BUILD_DIR/trellisShell_sim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
   echo "run.sh: simulation exited with status $simStatus"
   exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG_FILE"; then
   echo "run.sh: simulation passed"
   exit 0
fi

echo "run.sh: pass message not found in $LOG_FILE"
exit 1

// File: tb/trellisShell_sva.sv
/*
 * Trellis shell protocol checks
 * quadrary enable spacing, stretched enable width and
 * register state after reset, bound into the shell
 */
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellisShell_sva (
   input logic                   clk,
   input logic                   reset,
   input logic                   quadrarySymEnOut,
   input logic                   quadrarySym2xEnOut,
   input logic                   dac0Sync,
   input logic                   dac1Sync,
   input logic                   dac2Sync,
   input trellisPkg::phErrShft_t phErrShft,
   input trellisPkg::decay_t     decayFactor
);

   // --------------------
   // enables

   // at least 3 idle clocks before each quadrary enable
   enSpacing: assert property (@(posedge clk) disable iff (reset)
      quadrarySymEnOut |-> !$past(quadrarySymEnOut, 1) && !$past(quadrarySymEnOut, 2)
         && !$past(quadrarySymEnOut, 3))
      else $error("quadrary enable closer than 4 clocks to the previous one");

   // stretched enable never wider than two clocks
   en2xWidth: assert property (@(posedge clk) disable iff (reset)
      quadrarySym2xEnOut && $past(quadrarySym2xEnOut) |-> !$past(quadrarySym2xEnOut, 2))
      else $error("stretched 2x enable high for more than two clocks");

   // --------------------
   // reset state, one clock after any reset cycle
   resetState: assert property (@(posedge clk)
      reset |=> !dac0Sync && !dac1Sync && !dac2Sync && phErrShft == '0
         && decayFactor == `DECAY_RESET && quadrarySym2xEnOut == quadrarySymEnOut)
      else $error("register state after reset is wrong");

endmodule

bind trellisShell trellisShell_sva trellisShell_sva_i (
   .clk                (clk),
   .reset              (reset),
   .quadrarySymEnOut   (quadrarySymEnOut),
   .quadrarySym2xEnOut (quadrarySym2xEnOut),
   .dac0Sync           (dac0Sync),
   .dac1Sync           (dac1Sync),
   .dac2Sync           (dac2Sync),
   .phErrShft          (phErrShft),
   .decayFactor        (decayFactor)
);

// File: tb/trellisShell_tb.sv
/*
 * Trellis shell testbench
 * LCG stimulus at the 2x symbol rate, decay register writes and
 * reads, DAC select sweeps, reference models of the shell rules
 * and concurrent assertions on the DUT outputs
 */
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellisShell_tb;

   import trellisPkg::*;

   localparam int ClkPeriod = 100;
   localparam int NumTests = 300;
   // clocks per symbol period
   localparam int EnSpacing = 4;
   localparam int WatchdogClocks = NumTests * EnSpacing + 50;

   // DUT ports
   logic clk = 1'b0;
   logic reset, sym2xEn, wr0;
   sample_t iIn, qIn;
   phaseErr_t phaseError;
   trellisIndex_t index;
   regAddr_t addr;
   regData_t din, dout;
   dacSel_t dac0Select, dac1Select, dac2Select;
   logic dac0Sync, dac1Sync, dac2Sync;
   dacWord_t dac0Data, dac1Data, dac2Data;
   decay_t decayFactor;
   phErrShft_t phErrShft;
   logic quadrarySymEnOut, quadrarySym2xEnOut;

   // -------------------- reference model state
   decay_t modelDecay;
   logic modelEnDly, modelSync;
   phaseErr_t prevPhaseErr;
   phErrShft_t modelPhShft;
   sample_t modelI, modelQ;
   dacWord_t modelDac0, modelDac1, modelDac2;
   regData_t expDout;

   int errorCount = 0;
   int testCount = 0;
   int writeCount = 0;
   logic [31:0] lcgState = 32'd91;
   // saturator edge cases for every third enable
   phaseErr_t corners [6] = '{10'sd63, 10'sd64, -10'sd64, -10'sd65, 10'sd511, -10'sd511};

   trellisShell trellisShell_i (.*);

   always #(ClkPeriod / 2) clk = ~clk;

   function automatic logic [31:0] lcgNext();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // clamp rule for the loop-filter word
   function automatic phErrShft_t satWord(input phaseErr_t p);
      int pInt;
      int twice;
      pInt = int'(p);
      twice = 2 * pInt;
      if (pInt >= 64) begin
         return `PHSHFT_POS_SAT;
      end
      else if (pInt < -64) begin
         return `PHSHFT_NEG_SAT;
      end
      return twice[7:0];
   endfunction

   // monitor source by select code with phase error for unknown codes
   function automatic dacWord_t expectedDacWord(input dacSel_t sel, input sample_t i,
         input sample_t q, input phaseErr_t pe, input trellisIndex_t idx);
      case (sel)
         `DAC_TRELLIS_I: expectedDacWord = dacWord_t'(i);
         `DAC_TRELLIS_Q: expectedDacWord = dacWord_t'(q);
         `DAC_TRELLIS_INDEX: expectedDacWord = {idx, 12'h000};
         default: expectedDacWord = {pe, 8'h00};
      endcase
   endfunction

   task automatic reportMismatch(input string name, input logic [31:0] expVal,
         input logic [31:0] actVal);
      errorCount++;
      $display("Error %s expected %h actual %h at %0t", name, expVal, actVal, $time);
   endtask

   // --------------------
   // models step on the same edges as the DUT
   assign expDout = (addr == `TRELLIS_DECAY) ? {24'h000000, modelDecay} : '0;

   always @(posedge clk) begin
      if (reset) begin
         modelDecay   <= `DECAY_RESET;
         modelEnDly   <= 1'b0;
         modelSync    <= 1'b0;
         prevPhaseErr <= '0;
         modelPhShft  <= '0;
         modelDac0    <= '0;
         modelDac1    <= '0;
         modelDac2    <= '0;
      end
      else begin
         modelEnDly <= sym2xEn;
         modelSync  <= sym2xEn;
         if (wr0 && addr == `TRELLIS_DECAY) begin
            modelDecay <= din[7:0];
         end
         // output uses the error held at the enable before
         if (sym2xEn) begin
            modelPhShft  <= satWord(prevPhaseErr);
            prevPhaseErr <= phaseError;
         end
         modelDac0 <= expectedDacWord(dac0Select, modelI, modelQ, phaseError, index);
         modelDac1 <= expectedDacWord(dac1Select, modelI, modelQ, phaseError, index);
         modelDac2 <= expectedDacWord(dac2Select, modelI, modelQ, phaseError, index);
      end
      // I/Q latch also loads during reset
      if (sym2xEn) begin
         modelI <= iIn;
         modelQ <= qIn;
      end
   end

   // --------------------
   // output checks
   enPass: assert property (@(posedge clk) disable iff (reset) quadrarySymEnOut == sym2xEn)
      else reportMismatch("quadrarySymEnOut", 32'($sampled(sym2xEn)),
         32'($sampled(quadrarySymEnOut)));
   en2x: assert property (@(posedge clk) disable iff (reset)
      quadrarySym2xEnOut == (sym2xEn | modelEnDly))
      else reportMismatch("quadrarySym2xEnOut", 32'($sampled(sym2xEn | modelEnDly)),
         32'($sampled(quadrarySym2xEnOut)));
   satOut: assert property (@(posedge clk) disable iff (reset) phErrShft == modelPhShft)
      else reportMismatch("phErrShft", 32'($sampled(modelPhShft)), 32'($sampled(phErrShft)));
   decayReg: assert property (@(posedge clk) disable iff (reset) decayFactor == modelDecay)
      else reportMismatch("decayFactor", 32'($sampled(modelDecay)),
         32'($sampled(decayFactor)));
   readBack: assert property (@(posedge clk) disable iff (reset) dout == expDout)
      else reportMismatch("dout", $sampled(expDout), $sampled(dout));
   dacSyncs: assert property (@(posedge clk) disable iff (reset)
      {dac0Sync, dac1Sync, dac2Sync} == {3{modelSync}})
      else reportMismatch("dacSync", 32'({3{$sampled(modelSync)}}),
         {29'h0, $sampled(dac0Sync), $sampled(dac1Sync), $sampled(dac2Sync)});
   dac0Out: assert property (@(posedge clk) disable iff (reset) dac0Data == modelDac0)
      else reportMismatch("dac0Data", 32'($sampled(modelDac0)), 32'($sampled(dac0Data)));
   dac1Out: assert property (@(posedge clk) disable iff (reset) dac1Data == modelDac1)
      else reportMismatch("dac1Data", 32'($sampled(modelDac1)), 32'($sampled(dac1Data)));
   dac2Out: assert property (@(posedge clk) disable iff (reset) dac2Data == modelDac2)
      else reportMismatch("dac2Data", 32'($sampled(modelDac2)), 32'($sampled(dac2Data)));

   // --------------------
   // stimulus
   initial begin
      logic [31:0] r;
      regAddr_t nextAddr;
      reset = 1'b1;
      // enable during reset loads the I/Q latch
      sym2xEn = 1'b1;
      iIn = '0;
      qIn = '0;
      phaseError = '0;
      index = '0;
      wr0 = 1'b0;
      addr = '0;
      din = '0;
      dac0Select = '0;
      dac1Select = '0;
      dac2Select = '0;
      @(posedge clk);
      sym2xEn <= 1'b0;
      @(posedge clk);
      reset <= 1'b0;
      // idle clock keeps the first enable 4 clocks after the reset one
      @(posedge clk);
      for (int t = 0; t < NumTests; t++) begin
         for (int c = 0; c < EnSpacing; c++) begin
            @(posedge clk);
            r = lcgNext();
            sym2xEn <= (c == 0);
            wr0 <= (c == 1);
            phaseError <= r[31:22];
            index <= r[21:16];
            if (c == 0 && t % 3 == 0) begin
               phaseError <= corners[(t / 3) % 6];
            end
            r = lcgNext();
            iIn <= r[31:14];
            dac0Select <= r[13] ? {2'b00, r[12:11]} : r[12:9];
            r = lcgNext();
            qIn <= r[31:14];
            dac1Select <= r[13] ? {2'b00, r[12:11]} : r[12:9];
            r = lcgNext();
            din <= {r[15:0], r[31:16]};
            dac2Select <= r[13] ? {2'b00, r[12:11]} : r[12:9];
            // pick the decay register, another word in the space or any address
            if (c == 2 || r[9:8] < 2'd2) begin
               nextAddr = `TRELLIS_DECAY;
            end
            else if (r[9:8] == 2'd2) begin
               nextAddr = {`TRELLIS_SPACE_TAG, r[13:10]};
            end
            else begin
               nextAddr = r[31:20];
            end
            addr <= nextAddr;
            if (c == 1 && nextAddr == `TRELLIS_DECAY) begin
               writeCount++;
            end
         end
         testCount++;
      end
      repeat (2) @(posedge clk);
      $display("tests %0d, decay writes %0d, errors %0d", testCount, writeCount, errorCount);
      if (errorCount == 0) begin
         $display("*** TEST PASSED ***");
      end
      else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // --------------------
   // watchdog
   initial begin
      #(WatchdogClocks * ClkPeriod);
      $display("watchdog expired before the stimulus finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: verilog/phaseErrSat.sv
/*
 * Phase-error saturator
 * two-stage pipeline that doubles the decoder phase error and
 * clamps it to +/- full scale of the loop-filter word
 */
`timescale 1ns/1ps
`include "trellis_macros.svh"

module phaseErrSat (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   quadSymEn,
   input  trellisPkg::phaseErr_t  phaseError,
   output trellisPkg::phErrShft_t phErrShft
);

   import trellisPkg::*;

   // bits above the doubled field, sign included
   localparam int HeadBits = `PHERR_BITS - `PHSHFT_BITS + 2;

   logic [HeadBits-1:0] head;
   logic sign;

   // stage 1 registers
   phErrShft_t dataBits;
   logic satPos;
   logic satNeg;

   assign head = phaseError[`PHERR_BITS-1 -: HeadBits];
   assign sign = phaseError[`PHERR_BITS-1];

   // --------------------
   // both stages step on the quadrary enable
   always_ff @(posedge clk) begin
      if (reset) begin
         dataBits  <= '0;
         satPos    <= 1'b0;
         satNeg    <= 1'b0;
         phErrShft <= '0;
      end
      else if (quadSymEn) begin
         // stage 1, 2p and the overflow flags
         dataBits <= {phaseError[`PHSHFT_BITS-2:0], 1'b0};
         // p >= 64
         satPos   <= !sign && (head != '0);
         // p < -64
         satNeg   <= sign && (head != '1);
         // stage 2, uses the flags from the previous enable
         if (satPos) begin
            phErrShft <= `PHSHFT_POS_SAT;
         end
         else if (satNeg) begin
            phErrShft <= `PHSHFT_NEG_SAT;
         end
         else begin
            phErrShft <= dataBits;
         end
      end
   end

endmodule

// File: verilog/trellisCtrl.sv
/*
 * Trellis shell control
 * decodes the trellis register space, holds the decay factor,
 * drives the readback mux and derives the quadrary enables
 * from the 2x symbol enable
 */
`timescale 1ns/1ps
`include "trellis_macros.svh"

module trellisCtrl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 sym2xEn,
   input  logic                 wr0,
   input  trellisPkg::regAddr_t addr,
   input  trellisPkg::regData_t din,
   output trellisPkg::regData_t dout,
   output trellisPkg::decay_t   decayFactor,
   output logic                 quadSymEn,
   output logic                 quadSym2xEn
);

   // --------------------
   // address decode

   // decay register hit on the full address
   logic decayHit;

   assign decayHit = (addr == `TRELLIS_DECAY);

   // --------------------
   // decay register

   // a one-clock wr0 strobe takes effect on the next clock
   always_ff @(posedge clk) begin
      if (reset) begin
         decayFactor <= `DECAY_RESET;
      end
      else if (wr0 && decayHit) begin
         decayFactor <= din[`DECAY_BITS-1:0];
      end
   end

   // --------------------
   // readback

   // unmapped addresses read as zero
   always_comb begin
      dout = '0;
      if (decayHit) begin
         dout = {{(`REG_DATA_BITS-`DECAY_BITS){1'b0}}, decayFactor};
      end
   end

   // --------------------
   // quadrary enables

   // delayed copy of the quadrary enable
   logic quadSymEnDly;

   // without a carrier loop the 2x enable is the symbol enable
   assign quadSymEn = sym2xEn;

   always_ff @(posedge clk) begin
      if (reset) begin
         quadSymEnDly <= 1'b0;
      end
      else begin
         quadSymEnDly <= quadSymEn;
      end
   end

   // stretched to two clocks for the line decoder
   // relies on at least 3 idle clocks between enables
   assign quadSym2xEn = quadSymEn | quadSymEnDly;

endmodule

// File: verilog/trellisShell.sv
/*
 * Multi-h SOQPSK trellis demodulator shell
 * register space with decay factor, phase-error saturator for the
 * carrier loop filter, derived quadrary enables and three DAC
 * monitor channels around the external matched-filter/Viterbi core
 */
`timescale 1ns/1ps

module trellisShell (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     sym2xEn,
   input  trellisPkg::sample_t      iIn,
   input  trellisPkg::sample_t      qIn,
   input  trellisPkg::phaseErr_t    phaseError,
   input  trellisPkg::trellisIndex_t index,
   input  logic                     wr0,
   input  trellisPkg::regAddr_t     addr,
   input  trellisPkg::regData_t     din,
   input  trellisPkg::dacSel_t      dac0Select,
   input  trellisPkg::dacSel_t      dac1Select,
   input  trellisPkg::dacSel_t      dac2Select,
   output trellisPkg::regData_t     dout,
   output logic                     dac0Sync,
   output logic                     dac1Sync,
   output logic                     dac2Sync,
   output trellisPkg::dacWord_t     dac0Data,
   output trellisPkg::dacWord_t     dac1Data,
   output trellisPkg::dacWord_t     dac2Data,
   output trellisPkg::decay_t       decayFactor,
   output trellisPkg::phErrShft_t   phErrShft,
   output logic                     quadrarySymEnOut,
   output logic                     quadrarySym2xEnOut
);

   // --------------------
   // control: register space and quadrary enables
   // quadrary enable also paces the saturator and DAC syncs
   trellisCtrl trellisCtrl_i (
      .clk         (clk),
      .reset       (reset),
      .sym2xEn     (sym2xEn),
      .wr0         (wr0),
      .addr        (addr),
      .din         (din),
      .dout        (dout),
      .decayFactor (decayFactor),
      .quadSymEn   (quadrarySymEnOut),
      .quadSym2xEn (quadrarySym2xEnOut)
   );

   // --------------------
   // phase error to loop-filter word
   phaseErrSat phaseErrSat_i (
      .clk        (clk),
      .reset      (reset),
      .quadSymEn  (quadrarySymEnOut),
      .phaseError (phaseError),
      .phErrShft  (phErrShft)
   );

   // --------------------
   // I/Q latch and monitor channels
   dacMux dacMux_i (
      .clk        (clk),
      .reset      (reset),
      .sym2xEn    (sym2xEn),
      .quadSymEn  (quadrarySymEnOut),
      .iIn        (iIn),
      .qIn        (qIn),
      .phaseError (phaseError),
      .index      (index),
      .dac0Select (dac0Select),
      .dac1Select (dac1Select),
      .dac2Select (dac2Select),
      .dac0Sync   (dac0Sync),
      .dac1Sync   (dac1Sync),
      .dac2Sync   (dac2Sync),
      .dac0Data   (dac0Data),
      .dac1Data   (dac1Data),
      .dac2Data   (dac2Data)
   );

endmodule
